//--- src/l2_cfg.svh
`ifndef L2_CFG_SVH
`define L2_CFG_SVH

// cache geometry
`define L2_TAG_W    18
`define L2_INDEX_W  8
`define L2_WAYS     4
`define L2_SETS     256

// per-way age counter, wide enough for L2_WAYS distinct ages
`define L2_AGE_W    2

`endif

//--- src/cache_pkg.sv
`include "l2_cfg.svh"

package cache_pkg;

    typedef logic [`L2_TAG_W-1:0]        tag_t;
    typedef logic [`L2_INDEX_W-1:0]      index_t;
    typedef logic [$clog2(`L2_WAYS)-1:0] way_t;
    typedef logic [`L2_AGE_W-1:0]        age_t;

    // one set as seen by the tag lookup, 80 bits
    typedef struct packed {
        tag_t [`L2_WAYS-1:0] tag;
        logic [`L2_WAYS-1:0] valid;
        logic [`L2_WAYS-1:0] dirty;
    } set_tags_t;

    // ages of all ways in a set, 0 = most recently used
    typedef age_t [`L2_WAYS-1:0] set_ages_t;

endpackage

//--- src/ctrl_pkg.sv
package ctrl_pkg;

    // controller states
    typedef enum logic [1:0] {
        IDLE,
        COMPARE,
        WRITE_BACK,
        ALLOCATE
    } l2_state_t;

endpackage

//--- src/l2_ifs.sv
`timescale 1ns/1ps

`include "l2_cfg.svh"

// controller <-> tag/valid/dirty store
interface lookup_if;
    logic [`L2_INDEX_W-1:0]      index;
    logic [`L2_TAG_W-1:0]        tag;
    logic                        fill;
    logic [$clog2(`L2_WAYS)-1:0] fill_way;
    logic                        mark_dirty;
    logic                        flush;
    logic [$clog2(`L2_WAYS)-1:0] sel_way;     // way whose tag/dirty is read back

    logic                        hit;
    logic [$clog2(`L2_WAYS)-1:0] hit_way;
    logic [$clog2(`L2_WAYS)-1:0] victim_way;  // lowest invalid way
    logic                        all_valid;
    logic [`L2_TAG_W-1:0]        victim_tag;
    logic                        victim_dirty;

    modport ctrl (
        output index, tag, fill, fill_way, mark_dirty, flush, sel_way,
        input  hit, hit_way, victim_way, all_valid, victim_tag, victim_dirty
    );

    modport store (
        input  index, tag, fill, fill_way, mark_dirty, flush, sel_way,
        output hit, hit_way, victim_way, all_valid, victim_tag, victim_dirty
    );
endinterface

// controller <-> replacement ages
interface repl_if;
    logic [`L2_INDEX_W-1:0]      index;
    logic                        touch;
    logic [$clog2(`L2_WAYS)-1:0] touch_way;
    logic [$clog2(`L2_WAYS)-1:0] oldest_way;

    modport ctrl (output index, touch, touch_way, input oldest_way);
    modport store (input index, touch, touch_way, output oldest_way);
endinterface

//--- src/set_store.sv
`timescale 1ns/1ps

`include "l2_cfg.svh"

module set_store
    import cache_pkg::*;
#(
    parameter type entry_t = logic
)
(
    input  logic   clk,
    input  logic   nrst,
    input  index_t rd_index,
    output entry_t rd_entry,
    input  logic   wr_en,
    input  index_t wr_index,
    input  entry_t wr_entry,
    input  logic   clear
);

    entry_t mem [`L2_SETS];

    assign rd_entry = mem[rd_index]; // async read

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int i = 0; i < `L2_SETS; i++)
                mem[i] <= '0;
        end
        else if (clear)
        begin
            for (int i = 0; i < `L2_SETS; i++)
                mem[i] <= '0;
        end
        else if (wr_en)
            mem[wr_index] <= wr_entry;
    end

    // controller must keep flush apart from fills and touches
    a_no_wr_on_clear: assert property (@(posedge clk) disable iff (!nrst)
        !(wr_en && clear));

endmodule

//--- src/tag_lookup.sv
`timescale 1ns/1ps

`include "l2_cfg.svh"

module tag_lookup
    import cache_pkg::*;
(
    input logic     clk,
    input logic     nrst,
    lookup_if.store lk
);

    set_tags_t           cur;
    set_tags_t           nxt;
    logic [`L2_WAYS-1:0] match;

    set_store #(
        .entry_t (set_tags_t)
    ) tags_inst (
        .clk      (clk),
        .nrst     (nrst),
        .rd_index (lk.index),
        .rd_entry (cur),
        .wr_en    (lk.fill || lk.mark_dirty),
        .wr_index (lk.index),
        .wr_entry (nxt),
        .clear    (lk.flush)  // valid and dirty go together
    );

    always_comb
    begin
        for (int w = 0; w < `L2_WAYS; w++)
            match[w] = cur.valid[w] && (cur.tag[w] == lk.tag);
    end

    assign lk.hit       = |match;
    assign lk.all_valid = &cur.valid;

    // lowest-numbered way wins in both scans
    always_comb
    begin
        lk.hit_way    = '0;
        lk.victim_way = '0;
        for (int w = `L2_WAYS - 1; w >= 0; w--)
        begin
            if (match[w])
                lk.hit_way = way_t'(w);
            if (!cur.valid[w])
                lk.victim_way = way_t'(w);
        end
    end

    assign lk.victim_tag   = cur.tag[lk.sel_way];
    assign lk.victim_dirty = cur.dirty[lk.sel_way];

    // new set record, only the touched way changes
    always_comb
    begin
        nxt = cur;
        if (lk.fill)
        begin
            nxt.tag[lk.fill_way]   = lk.tag;
            nxt.valid[lk.fill_way] = 1'b1;
            nxt.dirty[lk.fill_way] = 1'b0;
        end
        if (lk.mark_dirty)
            nxt.dirty[lk.hit_way] = 1'b1;
    end

    // a tag is never filled twice into one set
    a_single_hit: assert property (@(posedge clk) disable iff (!nrst)
        $onehot0(match));

endmodule

//--- src/lru_replace.sv
`timescale 1ns/1ps

`include "l2_cfg.svh"

module lru_replace
    import cache_pkg::*;
(
    input logic   clk,
    input logic   nrst,
    repl_if.store rp,
    input logic   flush
);

    set_ages_t cur;
    set_ages_t nxt;
    age_t      old_age;
    age_t      best;

    set_store #(
        .entry_t (set_ages_t)
    ) ages_inst (
        .clk      (clk),
        .nrst     (nrst),
        .rd_index (rp.index),
        .rd_entry (cur),
        .wr_en    (rp.touch),
        .wr_index (rp.index),
        .wr_entry (nxt),
        .clear    (flush)
    );

    assign old_age = cur[rp.touch_way];

    // touched way goes to 0, younger-or-equal ways age by one, saturating
    always_comb
    begin
        nxt = cur;
        for (int w = 0; w < `L2_WAYS; w++)
        begin
            if (way_t'(w) == rp.touch_way)
                nxt[w] = '0;
            else if (cur[w] <= old_age && cur[w] < age_t'(`L2_WAYS - 1))
                nxt[w] = cur[w] + age_t'(1);
        end
    end

    // highest age, ties to lowest way
    always_comb
    begin
        best          = cur[0];
        rp.oldest_way = '0;
        for (int w = 1; w < `L2_WAYS; w++)
        begin
            if (cur[w] > best)
            begin
                best          = cur[w];
                rp.oldest_way = way_t'(w);
            end
        end
    end

    a_touch_known: assert property (@(posedge clk) disable iff (!nrst)
        rp.touch |-> !$isunknown(rp.touch_way));

endmodule

//--- src/l2_fsm.sv
`timescale 1ns/1ps

module l2_fsm
    import cache_pkg::*;
    import ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    nrst,
    lookup_if.ctrl  lk,
    repl_if.ctrl    rp,
    input  logic    req_read,
    input  logic    req_write,
    input  logic    flush,
    input  tag_t    req_tag,
    input  index_t  req_index,
    input  logic    mem_ready,
    output logic    ready,
    output logic    refill,
    output logic    update,
    output logic    mem_read,
    output logic    mem_write,
    output way_t    way,
    output index_t  mem_index,
    output tag_t    mem_tag,
    output tag_t    mem_wb_tag
);

    l2_state_t state;
    l2_state_t next_state;
    way_t      victim_q;
    way_t      victim_d;
    logic      req;
    logic      hit_now;
    logic      fill_now;

    // ready is still up in the IDLE cycle while L1 holds the old request
    assign req      = (req_read || req_write) && !ready;
    assign hit_now  = (state == COMPARE) && lk.hit;
    assign fill_now = (state == ALLOCATE) && mem_ready;

    // invalid way first, LRU way once the set is full
    assign victim_d = lk.all_valid ? rp.oldest_way : lk.victim_way;

    assign lk.index      = req_index;
    assign lk.tag        = req_tag;
    assign lk.fill       = fill_now;
    assign lk.fill_way   = victim_q;
    assign lk.mark_dirty = hit_now && req_write;
    assign lk.flush      = (state == IDLE) && flush && !req_read && !req_write;
    assign lk.sel_way    = (state == COMPARE) ? victim_d : victim_q;

    assign rp.index     = req_index;
    assign rp.touch     = hit_now;
    assign rp.touch_way = lk.hit_way;

    assign mem_read   = (state == ALLOCATE);
    assign mem_write  = (state == WRITE_BACK);
    assign mem_index  = req_index;
    assign mem_tag    = req_tag;
    assign mem_wb_tag = lk.victim_tag; // stable, set not written during write-back

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
                if (req)
                    next_state = COMPARE;
            COMPARE:
                if (lk.hit)
                    next_state = IDLE;
                else if (lk.victim_dirty)
                    next_state = WRITE_BACK;
                else
                    next_state = ALLOCATE;
            WRITE_BACK:
                if (mem_ready)
                    next_state = ALLOCATE;
            ALLOCATE:
                if (mem_ready)
                    next_state = COMPARE; // re-check, now hits
            default:
                next_state = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state    <= IDLE;
            victim_q <= '0;
            ready    <= 1'b0;
            refill   <= 1'b0;
            update   <= 1'b0;
            way      <= '0;
        end
        else
        begin
            state  <= next_state;
            ready  <= hit_now;
            update <= hit_now && req_write;
            refill <= fill_now;
            if (state == COMPARE && !lk.hit)
                victim_q <= victim_d;
            if (hit_now)
                way <= lk.hit_way;
            else if (fill_now)
                way <= victim_q;
        end
    end

    a_mem_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(mem_read && mem_write));

    a_ready_pulse: assert property (@(posedge clk) disable iff (!nrst)
        ready |=> !ready);

endmodule

//--- src/l2_cache_ctrl.sv
`timescale 1ns/1ps

module l2_cache_ctrl
    import cache_pkg::*;
(
    input  logic    clk,
    input  logic    nrst,
    input  logic    req_read,
    input  logic    req_write,
    input  logic    flush,
    input  tag_t    req_tag,
    input  index_t  req_index,
    input  logic    mem_ready,
    output logic    ready,
    output logic    refill,
    output logic    update,
    output logic    mem_read,
    output logic    mem_write,
    output way_t    way,
    output index_t  mem_index,
    output tag_t    mem_tag,
    output tag_t    mem_wb_tag
);

    lookup_if lk_bus ();
    repl_if   rp_bus ();

    tag_lookup tag_lookup_inst (
        .clk  (clk),
        .nrst (nrst),
        .lk   (lk_bus.store)
    );

    // ages cleared by the same qualified flush as the valid bits
    lru_replace lru_replace_inst (
        .clk   (clk),
        .nrst  (nrst),
        .rp    (rp_bus.store),
        .flush (lk_bus.flush)
    );

    l2_fsm l2_fsm_inst (
        .clk        (clk),
        .nrst       (nrst),
        .lk         (lk_bus.ctrl),
        .rp         (rp_bus.ctrl),
        .req_read   (req_read),
        .req_write  (req_write),
        .flush      (flush),
        .req_tag    (req_tag),
        .req_index  (req_index),
        .mem_ready  (mem_ready),
        .ready      (ready),
        .refill     (refill),
        .update     (update),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .way        (way),
        .mem_index  (mem_index),
        .mem_tag    (mem_tag),
        .mem_wb_tag (mem_wb_tag)
    );

endmodule

//--- tests/tb_l2_cache_ctrl.sv
`timescale 1ns/1ps

`include "l2_cfg.svh"

module tb_l2_cache_ctrl
    import cache_pkg::*;
();

    localparam int N_REQ   = 35;
    localparam int MAX_CYC = N_REQ * (2 * 8 + 4 + 4) + 50; // +4 for responder lag and gaps

    logic   clk;
    logic   nrst;
    logic   req_read;
    logic   req_write;
    logic   flush;
    tag_t   req_tag;
    index_t req_index;
    logic   mem_ready;
    logic   ready;
    logic   refill;
    logic   update;
    logic   mem_read;
    logic   mem_write;
    way_t   way;
    index_t mem_index;
    tag_t   mem_tag;
    tag_t   mem_wb_tag;

    // reference model of the tag side
    tag_t m_tag   [`L2_SETS][`L2_WAYS];
    logic m_valid [`L2_SETS][`L2_WAYS];
    logic m_dirty [`L2_SETS][`L2_WAYS];
    age_t m_age   [`L2_SETS][`L2_WAYS];

    logic        exp_hit = 1'b0;
    way_t        exp_way = '0;
    logic        exp_wb = 1'b0;
    tag_t        exp_wb_tag = '0;
    logic        cur_write = 1'b0;
    logic        wb_seen = 1'b0;
    logic        started = 1'b0;
    logic [31:0] stim_seed = 32'd65;
    int          cycles = 0;
    int          err_value = 0;
    int          err_proto = 0;

    l2_cache_ctrl l2_cache_ctrl_inst (.*);

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycles <= cycles + 1;
        if (mem_write)
            wb_seen <= 1'b1;
    end

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] got);
        err_value++;
        $display("[FAIL] %s: expected 0x%0h, got 0x%0h", name, exp, got);
    endtask

    task automatic report_protocol(input string what);
        err_proto++;
        $display("protocol error: %s", what);
    endtask

    task automatic finish_run();
        $display("errors: %0d wrong values, %0d protocol", err_value, err_proto);
        if (err_value + err_proto == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    endtask

    function automatic void clear_model();
        for (int s = 0; s < `L2_SETS; s++)
        begin
            for (int w = 0; w < `L2_WAYS; w++)
            begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = '0;
            end
        end
    endfunction

    // lowest invalid way, else the oldest, ties to the lowest
    function automatic way_t pick_victim(input index_t ix);
        way_t v;
        logic any_free;
        v = '0;
        any_free = 1'b0;
        for (int i = `L2_WAYS - 1; i >= 0; i--)
        begin
            if (!m_valid[ix][i])
            begin
                v = way_t'(i);
                any_free = 1'b1;
            end
        end
        if (any_free)
            return v;
        for (int i = 1; i < `L2_WAYS; i++)
        begin
            if (m_age[ix][i] > m_age[ix][v])
                v = way_t'(i);
        end
        return v;
    endfunction

    function automatic void touch_model(input index_t ix, input way_t w);
        age_t old;
        old = m_age[ix][w];
        for (int i = 0; i < `L2_WAYS; i++)
        begin
            if (i != w && m_age[ix][i] <= old && m_age[ix][i] < `L2_WAYS - 1)
                m_age[ix][i]++;
        end
        m_age[ix][w] = '0;
    endfunction

    // one L1 request, model updated up front, then wait for ready
    task automatic access(input logic wr, input tag_t t, input index_t ix);
        way_t w;
        logic found;
        w = '0;
        found = 1'b0;
        exp_wb = 1'b0;
        for (int i = 0; i < `L2_WAYS; i++)
        begin
            if (m_valid[ix][i] && m_tag[ix][i] == t)
            begin
                found = 1'b1;
                w = way_t'(i);
            end
        end
        if (!found)
        begin
            w = pick_victim(ix);
            exp_wb = m_dirty[ix][w];
            exp_wb_tag = m_tag[ix][w];
            m_tag[ix][w] = t;
            m_valid[ix][w] = 1'b1;
            m_dirty[ix][w] = 1'b0;
        end
        touch_model(ix, w);
        if (wr)
            m_dirty[ix][w] = 1'b1;
        exp_hit = found;
        exp_way = w;
        cur_write = wr;
        wb_seen = 1'b0;
        started = 1'b1;
        req_tag = t;
        req_index = ix;
        req_read = !wr;
        req_write = wr;
        @(posedge clk);
        #10;
        while (!ready)
        begin
            @(posedge clk);
            #10;
        end
        req_read = 1'b0;
        req_write = 1'b0;
        @(posedge clk);
        #10;
    endtask

    task automatic flush_cache();
        flush = 1'b1;
        @(posedge clk);
        #10;
        flush = 1'b0;
        clear_model();
    endtask

    // memory side, answers every strobe after 1 to 8 cycles
    initial
    begin
        logic [31:0] seed;
        int          wait_cyc;
        seed = 32'd65;
        forever
        begin
            @(posedge clk);
            #10;
            if (mem_read || mem_write)
            begin
                seed = lcg_step(seed);
                wait_cyc = 1 + seed[18:16];
                repeat (wait_cyc - 1)
                    @(posedge clk);
                #10 mem_ready = 1'b1;
                @(posedge clk);
                #10 mem_ready = 1'b0;
            end
        end
    end

    initial
    begin
        wait (cycles >= MAX_CYC);
        report_protocol("timeout, the run did not finish within the cycle limit");
        finish_run();
    end

    a_idle_quiet: assert property (@(posedge clk) disable iff (!nrst)
        !started |-> {ready, refill, update, mem_read, mem_write, way} == 7'h0)
        else report_mismatch("ready/refill/update/mem_read/mem_write/way", 0,
            $sampled({ready, refill, update, mem_read, mem_write, way}));

    a_ready_way: assert property (@(posedge clk) disable iff (!nrst)
        ready |-> way == exp_way)
        else report_mismatch("way", $sampled(exp_way), $sampled(way));

    a_update: assert property (@(posedge clk) disable iff (!nrst)
        ready |-> update == cur_write)
        else report_mismatch("update", $sampled(cur_write), $sampled(update));

    a_refill_way: assert property (@(posedge clk) disable iff (!nrst)
        refill |-> way == exp_way)
        else report_mismatch("way", $sampled(exp_way), $sampled(way));

    a_refill_ready: assert property (@(posedge clk) disable iff (!nrst)
        refill |=> ready)
        else report_protocol("no ready in the cycle after refill");

    // a miss ends with refill then ready, a hit never refills
    a_miss_refill: assert property (@(posedge clk) disable iff (!nrst)
        ready |-> $past(refill) == !exp_hit)
        else report_protocol("refill before ready does not match the expected hit or miss");

    a_hit_latency: assert property (@(posedge clk) disable iff (!nrst)
        $rose(req_read || req_write) && exp_hit |-> ##2 ready)
        else report_protocol("a hit did not answer two cycles after the request");

    a_mem_addr: assert property (@(posedge clk) disable iff (!nrst)
        mem_read |-> {mem_index, mem_tag} == {req_index, req_tag})
        else report_mismatch("mem_index/mem_tag", $sampled({req_index, req_tag}),
            $sampled({mem_index, mem_tag}));

    a_wb_tag: assert property (@(posedge clk) disable iff (!nrst)
        mem_write |-> mem_wb_tag == exp_wb_tag)
        else report_mismatch("mem_wb_tag", $sampled(exp_wb_tag), $sampled(mem_wb_tag));

    a_strobe_on_hit: assert property (@(posedge clk) disable iff (!nrst)
        (mem_read || mem_write) |-> !exp_hit && !ready)
        else report_protocol("memory strobe during a hit or together with ready");

    a_wb_clean: assert property (@(posedge clk) disable iff (!nrst)
        mem_write |-> exp_wb)
        else report_protocol("write-back of a victim that is not dirty");

    a_wb_missing: assert property (@(posedge clk) disable iff (!nrst)
        mem_read && exp_wb |-> wb_seen)
        else report_protocol("dirty victim refilled without a write-back");

    a_read_hold: assert property (@(posedge clk) disable iff (!nrst)
        mem_read && !mem_ready |=> mem_read)
        else report_protocol("mem_read dropped before mem_ready");

    a_write_hold: assert property (@(posedge clk) disable iff (!nrst)
        mem_write && !mem_ready |=> mem_write)
        else report_protocol("mem_write dropped before mem_ready");

    a_strobe_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(mem_read && mem_write))
        else report_protocol("mem_read and mem_write high together");

    initial
    begin
        nrst = 1'b0;
        req_read = 1'b0;
        req_write = 1'b0;
        flush = 1'b0;
        req_tag = '0;
        req_index = '0;
        mem_ready = 1'b0;
        clear_model();
        repeat (5)
            @(posedge clk);
        #10 nrst = 1'b1;
        repeat (3)
            @(posedge clk);
        #10;

        // empty set, then the same line again
        access(1'b0, 18'h100, 8'd5);
        access(1'b0, 18'h100, 8'd5);

        // dirty line in way 0 gets evicted by the fifth tag
        access(1'b1, 18'h100, 8'd5);
        for (int i = 1; i < 5; i++)
            access(1'b0, tag_t'(18'h100 + i), 8'd5);

        // set 9: fill, reorder the ages with hits, then evict twice
        for (int i = 0; i < 4; i++)
            access(1'b0, tag_t'(18'h200 + i), 8'd9);
        access(1'b0, 18'h201, 8'd9);
        access(1'b0, 18'h200, 8'd9);
        access(1'b0, 18'h203, 8'd9);
        access(1'b1, 18'h202, 8'd9);
        access(1'b0, 18'h204, 8'd9);
        access(1'b0, 18'h201, 8'd9);

        access(1'b0, 18'h104, 8'd5);
        flush_cache();
        access(1'b0, 18'h104, 8'd5);   // misses again after flush

        for (int n = 0; n < 16; n++)
        begin
            stim_seed = lcg_step(stim_seed);
            access(stim_seed[24], tag_t'(18'h300 + stim_seed[18:16] % 6),
                   index_t'(20 + stim_seed[20]));
        end

        repeat (3)
            @(posedge clk);
        finish_run();
    end

endmodule

//--- sim.f
+incdir+src
src/cache_pkg.sv
src/ctrl_pkg.sv
src/l2_ifs.sv
src/set_store.sv
src/tag_lookup.sv
src/lru_replace.sv
src/l2_fsm.sv
src/l2_cache_ctrl.sv
tests/tb_l2_cache_ctrl.sv

//--- Bender.yml
package:
  name: l2_cache_ctrl

sources:
  - include_dirs:
      - src
    files:
      - src/cache_pkg.sv
      - src/ctrl_pkg.sv
      - src/l2_ifs.sv
      - src/set_store.sv
      - src/tag_lookup.sv
      - src/lru_replace.sv
      - src/l2_fsm.sv
      - src/l2_cache_ctrl.sv
  - target: test
    include_dirs:
      - src
    files:
      - tests/tb_l2_cache_ctrl.sv
